/* hsst_rx_cfg_pkg.sv */
package hsst_rx_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Transceiver sizing
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned NUM_PLLS            = 2;     // PLLs that can clock a receive lane
    localparam int unsigned SYNC_STAGES         = 2;     // Flops in each status synchroniser

    //////////////////////////////////////////////////////////////////////
    // Debounce lengths in free-running clock cycles
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned DEB_CNT_WIDTH       = 12;    // Wide enough for the longest filter
    localparam int unsigned SIGDET_DEB_CYCLES   = 4;     // Signal detect settles quickly
    localparam int unsigned PLL_LOCK_DEB_CYCLES = 2048;  // PLL lock must hold steady this long
    localparam int unsigned CDR_DEB_CYCLES_DEF  = 2048;  // Default CDR lock filter length

    //////////////////////////////////////////////////////////////////////
    // Reset sequencing timers
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned ALIGN_TIMER_WIDTH   = 16;    // Holds the longest alignment window
    localparam int unsigned ALIGN_TIMEOUT_DEF   = 10000; // Cycles allowed for word alignment

    // Lane reset stays asserted this many cycles once the lane is powered up
    localparam int unsigned LANE_RST_CYCLES     = 8;

endpackage

/* hsst_rx_types_pkg.sv */
package hsst_rx_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // Per-lane status and debug force bits
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic sigdet;      // Signal present on the lane input
        logic cdr_align;   // CDR has locked to the incoming data
        logic word_align;  // PCS word aligner is synced
        logic pll_lock;    // Lane sees a locked PLL
    } lane_status_t;

    typedef struct packed {
        logic det;         // Forces signal detect high
        logic cdr;         // Forces CDR lock high
        logic lsm;         // Forces word alignment high
    } lane_force_t;

    //////////////////////////////////////////////////////////////////////
    // Per-lane reset controls towards the transceiver
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic lane_pd;     // Lane power-down
        logic lane_rst;    // Lane reset
        logic pma_rst;     // Receive PMA reset
        logic pcs_rst;     // Receive PCS reset
        logic done;        // Lane is up and word-aligned
    } lane_ctrl_t;

    typedef enum logic [2:0] {
        ST_PD          = 3'd0,
        ST_LANE_RST    = 3'd1,
        ST_WAIT_SIGDET = 3'd2,
        ST_PMA_RST     = 3'd3,
        ST_PCS_RST     = 3'd4,
        ST_DONE        = 3'd5
    } rx_fsm_state_e;

endpackage

/* rx_status_filter.sv */
`timescale 1ns/1ns
module rx_status_filter
    import hsst_rx_cfg_pkg::*;
    import hsst_rx_types_pkg::*;
#(
    parameter bit          PLL_SEL_BIT    = 1'b0,               // 0 selects PLL0 and 1 selects PLL1
    parameter int unsigned CDR_DEB_CYCLES = CDR_DEB_CYCLES_DEF
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [NUM_PLLS-1:0] i_pll_done,
    input  logic                i_lane_rst,     // Lane reset request, active high
    input  lane_status_t        i_raw_status,   // Straight from the transceiver
    input  lane_force_t         i_force,
    output lane_status_t        o_status,
    output logic                o_lane_run
);

    localparam int unsigned DEB_NUM    = 3;
    localparam int unsigned DEB_SIGDET = 0;
    localparam int unsigned DEB_CDR    = 1;
    localparam int unsigned DEB_PLL    = 2;
    localparam int unsigned DEB_LEN [DEB_NUM] = '{SIGDET_DEB_CYCLES, CDR_DEB_CYCLES,
                                                  PLL_LOCK_DEB_CYCLES};

    logic [5:0]                            sync_in;
    logic [SYNC_STAGES-1:0][5:0]           sync_q;
    logic                                  pll_done_s;
    logic                                  lane_rst_s;
    lane_status_t                          status_s;
    logic [DEB_NUM-1:0]                    deb_in;
    logic [DEB_NUM-1:0][DEB_CNT_WIDTH-1:0] deb_cnt;
    logic [DEB_NUM-1:0]                    deb_q;

    //////////////////////////////////////////////////////////////////////
    // Synchronisers
    //////////////////////////////////////////////////////////////////////

    assign sync_in = {i_pll_done[PLL_SEL_BIT], i_lane_rst, i_raw_status};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], sync_in};    // Oldest sample sits at the top
        end
    end

    assign {pll_done_s, lane_rst_s, status_s} = sync_q[SYNC_STAGES-1];

    //////////////////////////////////////////////////////////////////////
    // Rise debounce
    //////////////////////////////////////////////////////////////////////

    assign deb_in[DEB_SIGDET] = status_s.sigdet;
    assign deb_in[DEB_CDR]    = status_s.cdr_align;
    assign deb_in[DEB_PLL]    = status_s.pll_lock;

    // A filtered bit rises only after a full run of high samples and drops on the first low one
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            deb_cnt <= '0;
            deb_q   <= '0;
        end else begin
            for (int i = 0; i < DEB_NUM; i++) begin
                if (!deb_in[i]) begin
                    deb_cnt[i] <= '0;
                    deb_q[i]   <= 1'b0;
                end else if (deb_cnt[i] == DEB_CNT_WIDTH'(DEB_LEN[i] - 1)) begin
                    deb_q[i]   <= 1'b1;                       // Counter parks at its last value
                end else begin
                    deb_cnt[i] <= deb_cnt[i] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Debug overrides and lane enable
    //////////////////////////////////////////////////////////////////////

    assign o_status.sigdet     = deb_q[DEB_SIGDET] | i_force.det;
    assign o_status.cdr_align  = deb_q[DEB_CDR] | i_force.cdr;
    assign o_status.word_align = status_s.word_align | i_force.lsm;    // Synchronised only
    assign o_status.pll_lock   = deb_q[DEB_PLL];

    assign o_lane_run = pll_done_s & ~lane_rst_s;

endmodule

/* rx_lane_rst_fsm.sv */
`timescale 1ns/1ns
module rx_lane_rst_fsm
    import hsst_rx_cfg_pkg::*;
    import hsst_rx_types_pkg::*;
#(
    parameter int unsigned ALIGN_TIMEOUT = ALIGN_TIMEOUT_DEF    // Cycles to wait for word alignment
) (
    input  logic         clk,
    input  logic         i_rst_n,
    input  logic         i_lane_run,   // Selected PLL done and no lane reset request
    input  lane_status_t i_status,     // Filtered status from the lane filter
    output lane_ctrl_t   o_ctrl
);

    localparam int unsigned RST_CNT_W = $clog2(LANE_RST_CYCLES + 1);

    rx_fsm_state_e                state_q;
    rx_fsm_state_e                state_d;
    logic [RST_CNT_W-1:0]         rst_cnt_q;
    logic [ALIGN_TIMER_WIDTH-1:0] align_tmr_q;
    lane_ctrl_t                   ctrl_q;
    logic                         lane_up;
    logic                         rst_hold_end;
    logic                         align_expired;

    // Reset controls driven in each state
    function automatic lane_ctrl_t ctrl_for(rx_fsm_state_e st);
        lane_ctrl_t c;
        c = '{lane_pd: 1'b1, lane_rst: 1'b1, pma_rst: 1'b1, pcs_rst: 1'b1, done: 1'b0};
        case (st)
            ST_LANE_RST: begin
                c.lane_pd = 1'b0;
            end
            ST_WAIT_SIGDET: begin
                c.lane_pd  = 1'b0;
                c.lane_rst = 1'b0;
            end
            ST_PMA_RST: begin
                c.lane_pd  = 1'b0;
                c.lane_rst = 1'b0;
                c.pma_rst  = 1'b0;
            end
            ST_PCS_RST: begin
                c.lane_pd  = 1'b0;
                c.lane_rst = 1'b0;
                c.pma_rst  = 1'b0;
                c.pcs_rst  = 1'b0;
            end
            ST_DONE: begin
                c = '{lane_pd: 1'b0, lane_rst: 1'b0, pma_rst: 1'b0, pcs_rst: 1'b0, done: 1'b1};
            end
            default: begin
                // Powered down with every reset held
            end
        endcase
        return c;
    endfunction

    assign lane_up       = i_lane_run & i_status.pll_lock;
    assign rst_hold_end  = (rst_cnt_q == RST_CNT_W'(LANE_RST_CYCLES - 1));
    assign align_expired = (align_tmr_q == ALIGN_TIMER_WIDTH'(ALIGN_TIMEOUT - 1));

    //////////////////////////////////////////////////////////////////////
    // Next-state decision
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_PD: begin
                if (lane_up) begin
                    state_d = ST_LANE_RST;
                end
            end
            ST_LANE_RST: begin
                if (rst_hold_end) begin
                    state_d = ST_WAIT_SIGDET;
                end
            end
            ST_WAIT_SIGDET: begin
                if (i_status.sigdet) begin
                    state_d = ST_PMA_RST;
                end
            end
            ST_PMA_RST: begin
                if (i_status.cdr_align) begin
                    state_d = ST_PCS_RST;
                end
            end
            ST_PCS_RST: begin
                if (i_status.word_align) begin
                    state_d = ST_DONE;
                end else if (align_expired) begin
                    state_d = ST_WAIT_SIGDET;                       // Retry from the PMA reset
                end
            end
            ST_DONE: begin
                state_d = ST_DONE;
            end
            default: begin
                state_d = ST_PD;
            end
        endcase

        // Loss of signal restarts the receive path and loss of PLL or enable powers down
        if ((state_q inside {ST_PMA_RST, ST_PCS_RST, ST_DONE}) && !i_status.sigdet) begin
            state_d = ST_WAIT_SIGDET;
        end
        if (!lane_up) begin
            state_d = ST_PD;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // State, timers and registered controls
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_PD;
            ctrl_q  <= ctrl_for(ST_PD);
        end else begin
            state_q <= state_d;
            ctrl_q  <= ctrl_for(state_d);                           // Controls track the state register
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rst_cnt_q   <= '0;
            align_tmr_q <= '0;
        end else begin
            if (state_q == ST_LANE_RST && state_d == ST_LANE_RST) begin
                rst_cnt_q <= rst_cnt_q + 1'b1;
            end else begin
                rst_cnt_q <= '0;                                    // Starts from zero on entry
            end
            if (state_q == ST_PCS_RST && state_d == ST_PCS_RST) begin
                align_tmr_q <= align_tmr_q + 1'b1;
            end else begin
                align_tmr_q <= '0;
            end
        end
    end

    assign o_ctrl = ctrl_q;

endmodule

/* hsst_rx_rst_top.sv */
`timescale 1ns/1ns
module hsst_rx_rst_top
    import hsst_rx_cfg_pkg::*;
    import hsst_rx_types_pkg::*;
#(
    parameter int unsigned          NUM_LANES      = 4,
    parameter logic [NUM_LANES-1:0] PLL_SEL        = '0,                  // Bit n set puts lane n on PLL1
    parameter int unsigned          CDR_DEB_CYCLES = CDR_DEB_CYCLES_DEF,
    parameter int unsigned          ALIGN_TIMEOUT  = ALIGN_TIMEOUT_DEF
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic         [NUM_PLLS-1:0]   i_pll_done,
    input  logic         [NUM_LANES-1:0]  i_lane_rst,     // One reset request per lane
    input  lane_status_t [NUM_LANES-1:0]  i_lane_status,  // Asynchronous to clk
    input  lane_force_t  [NUM_LANES-1:0]  i_lane_force,
    output lane_ctrl_t   [NUM_LANES-1:0]  o_lane_ctrl
);

    lane_status_t [NUM_LANES-1:0] filt_status;
    logic         [NUM_LANES-1:0] lane_run;

    //////////////////////////////////////////////////////////////////////
    // One status filter and one reset FSM per lane
    //////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane

        rx_status_filter #(
            .PLL_SEL_BIT    (PLL_SEL[n]),
            .CDR_DEB_CYCLES (CDR_DEB_CYCLES)
        ) i_filter (
            .clk            (clk),
            .i_rst_n        (i_rst_n),
            .i_pll_done     (i_pll_done),
            .i_lane_rst     (i_lane_rst[n]),
            .i_raw_status   (i_lane_status[n]),
            .i_force        (i_lane_force[n]),
            .o_status       (filt_status[n]),
            .o_lane_run     (lane_run[n])
        );

        rx_lane_rst_fsm #(
            .ALIGN_TIMEOUT  (ALIGN_TIMEOUT)
        ) i_fsm (
            .clk            (clk),
            .i_rst_n        (i_rst_n),
            .i_lane_run     (lane_run[n]),
            .i_status       (filt_status[n]),
            .o_ctrl         (o_lane_ctrl[n])
        );

    end

endmodule

/* hsst_rx_rst_sva.sv */
`timescale 1ns/1ns
module hsst_rx_rst_sva
    import hsst_rx_cfg_pkg::*;
    import hsst_rx_types_pkg::*;
#(
    parameter int unsigned NUM_LANES     = 4,
    parameter int unsigned ALIGN_TIMEOUT = ALIGN_TIMEOUT_DEF
) (
    input logic                       clk,
    input logic                       i_rst_n,
    input lane_ctrl_t [NUM_LANES-1:0] i_lane_ctrl
);

    int unsigned fail_cnt = 0;    // Summed into the testbench error total

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane

        int unsigned hold_cnt;     // Cycles powered up with lane reset still held
        int unsigned pcs_low_cnt;  // Cycles of released PCS reset without done

        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                hold_cnt    <= 0;
                pcs_low_cnt <= 0;
            end else begin
                if (!i_lane_ctrl[n].lane_pd && i_lane_ctrl[n].lane_rst) begin
                    hold_cnt <= hold_cnt + 1;
                end else begin
                    hold_cnt <= 0;
                end
                if (!i_lane_ctrl[n].pcs_rst && !i_lane_ctrl[n].done) begin
                    pcs_low_cnt <= pcs_low_cnt + 1;
                end else begin
                    pcs_low_cnt <= 0;
                end
            end
        end

        a_rst_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
            (!i_lane_ctrl[n].lane_pd && $fell(i_lane_ctrl[n].lane_rst))
                |-> (hold_cnt == LANE_RST_CYCLES))
        else begin
            fail_cnt++;
            $error("Lane %0d held lane reset for %0d cycles", n, hold_cnt);
        end

        // PCS must never leave reset ahead of the PMA
        a_rst_order: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_lane_ctrl[n].pma_rst |-> i_lane_ctrl[n].pcs_rst)
        else begin
            fail_cnt++;
            $error("Lane %0d released PCS reset while PMA reset is held", n);
        end

        a_done_clean: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_lane_ctrl[n].done |-> (i_lane_ctrl[n][4:1] == 4'b0000))
        else begin
            fail_cnt++;
            $error("Lane %0d reports done with a reset still asserted", n);
        end

        a_align_window: assert property (@(posedge clk) disable iff (!i_rst_n)
            pcs_low_cnt <= ALIGN_TIMEOUT + 1)
        else begin
            fail_cnt++;
            $error("Lane %0d kept PCS reset released past the alignment window", n);
        end

    end

endmodule

bind hsst_rx_rst_top hsst_rx_rst_sva #(
    .NUM_LANES     (NUM_LANES),
    .ALIGN_TIMEOUT (ALIGN_TIMEOUT)
) i_sva (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_lane_ctrl (o_lane_ctrl)
);

/* tb_hsst_rx_rst.sv */
`timescale 1ns/1ns
module tb_hsst_rx_rst
    import hsst_rx_cfg_pkg::*;
    import hsst_rx_types_pkg::*;
();

    localparam int unsigned NUM_LANES   = 4;
    localparam int unsigned CDR_CYCLES  = 20;
    localparam int unsigned ALIGN_TMO   = 64;
    localparam int unsigned CYCLE_LIMIT = 20000;   // About 2.1k for the PLL lock test, rest short
    localparam int F_PD   = 0;
    localparam int F_RST  = 1;
    localparam int F_PMA  = 2;
    localparam int F_PCS  = 3;
    localparam int F_DONE = 4;

    logic                         clk;
    logic                         rst_n;
    logic [NUM_PLLS-1:0]          pll_done;
    logic [NUM_LANES-1:0]         lane_rst;
    lane_status_t [NUM_LANES-1:0] lane_status;
    lane_force_t  [NUM_LANES-1:0] lane_force;
    lane_ctrl_t   [NUM_LANES-1:0] lane_ctrl;

    logic [15:0]  lfsr = 16'd9197;
    int unsigned  err_cnt = 0;
    int unsigned  test_cnt = 0;
    int unsigned  bad_tests = 0;
    int unsigned  test_base = 0;
    int unsigned  cycle_cnt = 0;
    int unsigned  width;

    hsst_rx_rst_top #(
        .NUM_LANES      (NUM_LANES),
        .PLL_SEL        (4'b1000),          // Lane 3 runs from PLL1
        .CDR_DEB_CYCLES (CDR_CYCLES),
        .ALIGN_TIMEOUT  (ALIGN_TMO)
    ) i_dut (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_pll_done     (pll_done),
        .i_lane_rst     (lane_rst),
        .i_lane_status  (lane_status),
        .i_lane_force   (lane_force),
        .o_lane_ctrl    (lane_ctrl)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock and run limit
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic ctrl_bit(input lane_ctrl_t c, input int fld);
        case (fld)
            F_PD:    return c.lane_pd;
            F_RST:   return c.lane_rst;
            F_PMA:   return c.pma_rst;
            F_PCS:   return c.pcs_rst;
            default: return c.done;
        endcase
    endfunction

    function automatic string fld_name(input int fld);
        case (fld)
            F_PD:    return "lane_pd";
            F_RST:   return "lane_rst";
            F_PMA:   return "pma_rst";
            F_PCS:   return "pcs_rst";
            default: return "done";
        endcase
    endfunction

    function automatic bit lanes_at(input int fld, input logic val,
                                    input logic [NUM_LANES-1:0] mask);
        bit ok;
        ok = 1'b1;
        for (int n = 0; n < NUM_LANES; n++) begin
            if (mask[n] && ctrl_bit(lane_ctrl[n], fld) != val) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic int unsigned total_errors();
        return err_cnt + i_dut.i_sva.fail_cnt;
    endfunction

    // Inputs change and outputs are read 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic show_mismatch(input string sig, input logic exp, input logic act);
        $display("mismatch at %0t ns: %s expected %0b got %0b", $time, sig, exp, act);
        err_cnt++;
    endtask

    task automatic expect_at(input int fld, input logic val, input logic [NUM_LANES-1:0] mask);
        for (int n = 0; n < NUM_LANES; n++) begin
            if (mask[n]) begin
                assert (ctrl_bit(lane_ctrl[n], fld) == val)
                else show_mismatch($sformatf("o_lane_ctrl[%0d].%s", n, fld_name(fld)), val,
                                   ctrl_bit(lane_ctrl[n], fld));
            end
        end
    endtask

    task automatic wait_for(input int fld, input logic val, input logic [NUM_LANES-1:0] mask,
                            input int unsigned max_cycles);
        int unsigned cyc;
        cyc = 0;
        while (!lanes_at(fld, val, mask) && cyc < max_cycles) begin
            next_cycle();
            cyc++;
        end
        expect_at(fld, val, mask);
    endtask

    task automatic set_status(input logic sd, input logic cdr, input logic wa, input logic pll);
        for (int n = 0; n < NUM_LANES; n++) begin
            lane_status[n] = '{sigdet: sd, cdr_align: cdr, word_align: wa, pll_lock: pll};
        end
    endtask

    task automatic pulse_lane_rst();
        lane_rst = '1;
        repeat (4) next_cycle();
        lane_rst = '0;
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one shift per bit handed out
    function automatic int unsigned draw_bits(input int unsigned nbits);
        int unsigned v;
        v = 0;
        for (int unsigned i = 0; i < nbits; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | 32'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic close_test(input string name);
        int unsigned now_err;
        now_err = total_errors();
        test_cnt++;
        if (now_err != test_base) begin
            bad_tests++;
        end
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (now_err == test_base) ? "ok" : "bad", now_err - test_base);
        test_base = now_err;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        pll_done    = '0;
        lane_rst    = '0;
        lane_status = '0;
        lane_force  = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (2) next_cycle();
        expect_at(F_PD, 1'b1, '1);
        expect_at(F_RST, 1'b1, '1);
        expect_at(F_PMA, 1'b1, '1);
        expect_at(F_PCS, 1'b1, '1);
        expect_at(F_DONE, 1'b0, '1);
        close_test("reset values");

        pll_done = '1;
        set_status(1'b0, 1'b0, 1'b0, 1'b1);
        wait_for(F_RST, 1'b0, '1, PLL_LOCK_DEB_CYCLES + LANE_RST_CYCLES + 40);
        set_status(1'b1, 1'b0, 1'b0, 1'b1);
        wait_for(F_PMA, 1'b0, '1, 30);
        set_status(1'b1, 1'b1, 1'b0, 1'b1);
        wait_for(F_PCS, 1'b0, '1, CDR_CYCLES + 30);
        set_status(1'b1, 1'b1, 1'b1, 1'b1);
        wait_for(F_DONE, 1'b1, '1, 30);
        close_test("ordered release");

        set_status(1'b1, 1'b1, 1'b0, 1'b1);
        pulse_lane_rst();
        wait_for(F_PD, 1'b1, '1, 10);
        wait_for(F_PCS, 1'b0, '1, LANE_RST_CYCLES + 40);
        repeat (2) begin
            wait_for(F_PCS, 1'b1, '1, ALIGN_TMO + 10);         // Timer expiry puts PCS back in reset
            expect_at(F_DONE, 1'b0, '1);
            wait_for(F_PCS, 1'b0, '1, 20);
        end
        set_status(1'b1, 1'b1, 1'b1, 1'b1);
        wait_for(F_DONE, 1'b1, '1, ALIGN_TMO + 30);
        close_test("alignment timeout");

        repeat (4) begin
            width = draw_bits(3);
            lane_status[0].sigdet = 1'b0;
            repeat (width + 1) next_cycle();                    // Glitch of 1 to 8 cycles
            lane_status[0].sigdet = 1'b1;
            wait_for(F_PMA, 1'b1, 4'b0001, 12);
            expect_at(F_DONE, 1'b0, 4'b0001);
            expect_at(F_DONE, 1'b1, 4'b1110);
            wait_for(F_DONE, 1'b1, 4'b0001, CDR_CYCLES + 30);
        end
        close_test("signal loss");

        lane_force = '1;
        set_status(1'b0, 1'b0, 1'b0, 1'b1);
        pulse_lane_rst();
        wait_for(F_PD, 1'b1, '1, 10);
        wait_for(F_DONE, 1'b1, '1, LANE_RST_CYCLES + 40);
        close_test("force override");

        pll_done = 2'b01;
        pulse_lane_rst();
        wait_for(F_PD, 1'b1, '1, 10);
        wait_for(F_DONE, 1'b1, 4'b0111, LANE_RST_CYCLES + 40);
        repeat (20) begin
            next_cycle();
            expect_at(F_PD, 1'b1, 4'b1000);                     // PLL1 is still not done
        end
        close_test("pll select");

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 test_cnt, bad_tests, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hsst_rx_cfg_pkg.sv
hsst_rx_types_pkg.sv
rx_status_filter.sv
rx_lane_rst_fsm.sv
hsst_rx_rst_top.sv
hsst_rx_rst_sva.sv
tb_hsst_rx_rst.sv

/* Makefile */
SIM      := verilator
TOP      := tb_hsst_rx_rst
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(filter %.sv %.v,$(shell cat $(FILELIST)))
RUN_ARGS := +verilator+error+limit+1000

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
